// File: include/jtag_debug_params.svh
`ifndef JTAG_DEBUG_PARAMS_SVH
`define JTAG_DEBUG_PARAMS_SVH

// Instruction register length
`define JTAG_IR_LEN 4

// CDPACC scan chain, ACK plus read data on capture
`define CDP_DR_LEN 36

// Device identification code
`define JTAG_IDCODE 32'h1BA0_0477

// Debug bus geometry
`define MEMI_NR_SLAVES 2
`define MEMI_ADDR_WIDTH 5

// Flops per clock domain crossing
`define SYNC_STAGES 2

`endif

// File: jtag_debug_top.f
+incdir+include
logic/jtag_debug_pkg.sv
logic/jtag_tap_fsm.sv
logic/jtag_ir.sv
logic/core_dbg_port.sv
logic/cdp_memi_bridge.sv
logic/dbg_reg_bank.sv
logic/jtag_debug_top.sv
verification/jtag_debug_tb.sv

// File: logic/cdp_memi_bridge.sv
`timescale 1ns/100ps
`include "jtag_debug_params.svh"

module cdp_memi_bridge (
    input  logic                      memi_clk,
    input  logic                      memi_rst,
    input  logic                      xfer_req,
    input  jtag_debug_pkg::cdp_cmd_s  xfer_cmd,
    output logic                      xfer_ack,
    output logic [31:0]               xfer_rdata,
    output jtag_debug_pkg::memi_req_s memi,
    input  logic [31:0]               memi_rdata
);
    import jtag_debug_pkg::*;

    logic [`SYNC_STAGES-1:0] req_sync; // req into memi_clk domain
    logic                    req_seen;
    br_state_e               state;

    assign req_seen = req_sync[`SYNC_STAGES-1];

    always_ff @(posedge memi_clk) begin
        if (memi_rst) begin
            req_sync <= '0;
            state    <= BR_IDLE;
            xfer_ack <= 1'b0;
            memi.sel <= '0; // Bus idle
        end else begin
            req_sync <= {req_sync[`SYNC_STAGES-2:0], xfer_req};
            case (state)
                BR_IDLE: begin
                    if (req_seen) begin
                        memi.sel   <= xfer_cmd.sel; // Setup cycle starts
                        memi.wr_rd <= xfer_cmd.wr;
                        memi.addr  <= xfer_cmd.addr;
                        memi.wdata <= xfer_cmd.wdata;
                        state      <= BR_SETUP;
                    end
                end
                BR_SETUP: begin
                    state <= BR_ACCESS; // Same bus values held
                end
                BR_ACCESS: begin
                    xfer_rdata <= memi_rdata; // Sampled at end of access
                    memi.sel   <= '0;
                    xfer_ack   <= 1'b1; // Phase 3
                    state      <= BR_ACK;
                end
                BR_ACK: begin
                    if (!req_seen) begin
                        xfer_ack <= 1'b0; // Phase 5
                        state    <= BR_IDLE;
                    end
                end
                default: begin
                    state <= BR_IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/core_dbg_port.sv
`timescale 1ns/100ps
`include "jtag_debug_params.svh"

module core_dbg_port (
    input  logic                     tck,
    input  logic                     state_test_logic_reset,
    input  logic                     insn_cdpacc_select,
    input  logic                     state_capture_dr,
    input  logic                     state_shift_dr,
    input  logic                     state_update_dr,
    input  logic                     tdi,
    output logic                     cdpacc_tdo,
    output logic                     xfer_req,
    output jtag_debug_pkg::cdp_cmd_s xfer_cmd,
    input  logic                     xfer_ack,
    input  logic [31:0]              xfer_rdata
);
    import jtag_debug_pkg::*;

    logic [`CDP_DR_LEN-1:0]     cdpacc_reg;  // ACK in [3:0], data in [35:4]
    logic [31:0]                select_reg;
    logic [`MEMI_ADDR_WIDTH-1:0] taddr_reg;
    logic [31:0]                dtr_wdata;
    logic [`SYNC_STAGES-1:0]    ack_sync;    // ack into tck domain
    cdp_ack_e                   status;      // Sticky ACK
    cdp_ack_e                   capture_ack;
    logic [31:0]                rd_result;   // Last read data
    logic [`MEMI_NR_SLAVES-1:0] sel_onehot;

    logic        upd_en;
    logic        upd_wr;
    cdp_op_e     upd_op;
    logic [31:0] upd_data;
    logic        busy;
    logic        sel_valid;
    logic        start;
    logic        done;

    // Update-DR fields
    assign upd_en   = insn_cdpacc_select && state_update_dr;
    assign upd_wr   = cdpacc_reg[0];
    assign upd_op   = cdp_op_e'(cdpacc_reg[3:1]);
    assign upd_data = cdpacc_reg[`CDP_DR_LEN-1:4];

    assign busy       = xfer_req || ack_sync[`SYNC_STAGES-1]; // Handshake not back to idle
    assign sel_valid  = (select_reg < `MEMI_NR_SLAVES);
    assign sel_onehot = {{(`MEMI_NR_SLAVES-1){1'b0}}, 1'b1} << select_reg;
    assign start      = upd_en && (upd_op == OP_DTR) && !busy && sel_valid;
    assign done       = xfer_req && ack_sync[`SYNC_STAGES-1];

    assign capture_ack = busy ? ACK_WAIT : status;
    assign cdpacc_tdo  = cdpacc_reg[0];

    // CDPACC scan chain
    always_ff @(posedge tck) begin
        if (insn_cdpacc_select && state_capture_dr) begin
            cdpacc_reg <= {rd_result, capture_ack};
        end else if (insn_cdpacc_select && state_shift_dr) begin
            cdpacc_reg <= {tdi, cdpacc_reg[`CDP_DR_LEN-1:1]};
        end
    end

    // Address, write data and command held for the bridge
    always_ff @(posedge tck) begin
        if (upd_en && (upd_op == OP_TADDR)) begin
            taddr_reg <= upd_data[`MEMI_ADDR_WIDTH-1:0];
        end
        if (upd_en && (upd_op == OP_DTR) && upd_wr) begin
            dtr_wdata <= upd_data;
        end
        if (start) begin
            xfer_cmd.wr    <= upd_wr;
            xfer_cmd.sel   <= sel_onehot;
            xfer_cmd.addr  <= taddr_reg;
            xfer_cmd.wdata <= upd_wr ? upd_data : dtr_wdata; // New DTR data wins
        end
    end

    always_ff @(posedge tck) begin
        if (state_test_logic_reset) begin
            xfer_req   <= 1'b0;
            ack_sync   <= '0;
            status     <= ACK_OK;
            rd_result  <= '0;
            select_reg <= '0;
        end else begin
            ack_sync <= {ack_sync[`SYNC_STAGES-2:0], xfer_ack};
            if (status == ACK_WAIT && !busy) begin
                status <= ACK_OK; // Dropped command cleared once idle
            end
            if (done) begin
                xfer_req <= 1'b0; // Phase 4
                if (!xfer_cmd.wr) begin
                    rd_result <= xfer_rdata;
                end
            end
            if (upd_en && (upd_op == OP_SELECT)) begin
                select_reg <= upd_data;
                if (status == ACK_FAULT) begin
                    status <= ACK_OK;
                end
            end
            if (upd_en && (upd_op == OP_DTR)) begin
                if (busy) begin
                    status <= ACK_WAIT; // Only back-pressure
                end else if (!sel_valid) begin
                    status <= ACK_FAULT;
                end
            end
            if (start) begin
                xfer_req <= 1'b1; // Phase 1, cmd loads same edge
            end
        end
    end

endmodule

// File: logic/dbg_reg_bank.sv
`timescale 1ns/100ps
`include "jtag_debug_params.svh"

module dbg_reg_bank (
    input  logic                      memi_clk,
    input  logic                      memi_rst,
    input  jtag_debug_pkg::memi_req_s memi,
    output logic [31:0]               memi_rdata
);

    logic [31:0] mem [`MEMI_NR_SLAVES][1 << `MEMI_ADDR_WIDTH]; // Per-slave words
    logic        access_phase; // Second cycle of a bus access

    always_ff @(posedge memi_clk) begin
        if (memi_rst) begin
            for (int s = 0; s < `MEMI_NR_SLAVES; s++) begin
                for (int w = 0; w < (1 << `MEMI_ADDR_WIDTH); w++) begin
                    mem[s][w] <= '0;
                end
            end
            access_phase <= 1'b0;
        end else begin
            access_phase <= (memi.sel != '0) && !access_phase;
            for (int s = 0; s < `MEMI_NR_SLAVES; s++) begin
                if (access_phase && memi.sel[s] && memi.wr_rd) begin
                    mem[s][memi.addr] <= memi.wdata; // End of access cycle
                end
            end
        end
    end

    // Combinational read of the selected slave
    always_comb begin
        memi_rdata = '0;
        for (int s = 0; s < `MEMI_NR_SLAVES; s++) begin
            if (memi.sel[s]) begin
                memi_rdata |= mem[s][memi.addr];
            end
        end
    end

endmodule

// File: logic/jtag_debug_pkg.sv
`include "jtag_debug_params.svh"

package jtag_debug_pkg;

    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'd0,
        RUN_TEST_IDLE    = 4'd1,
        SELECT_DR_SCAN   = 4'd2,
        CAPTURE_DR       = 4'd3,
        SHIFT_DR         = 4'd4,
        EXIT1_DR         = 4'd5,
        PAUSE_DR         = 4'd6,
        EXIT2_DR         = 4'd7,
        UPDATE_DR        = 4'd8,
        SELECT_IR_SCAN   = 4'd9,
        CAPTURE_IR       = 4'd10,
        SHIFT_IR         = 4'd11,
        EXIT1_IR         = 4'd12,
        PAUSE_IR         = 4'd13,
        EXIT2_IR         = 4'd14,
        UPDATE_IR        = 4'd15
    } tap_state_e;

    typedef enum logic [3:0] {
        INSN_IDCODE = 4'd1,
        INSN_CDPACC = 4'd10,
        INSN_BYPASS = 4'd15
    } jtag_insn_e;

    typedef enum logic [2:0] {
        OP_SELECT = 3'd0,
        OP_TADDR  = 3'd1,
        OP_DTR    = 3'd2
    } cdp_op_e;

    typedef enum logic [3:0] {
        ACK_OK    = 4'd1, // Last access done
        ACK_WAIT  = 4'd2, // Access running or command dropped
        ACK_FAULT = 4'd4  // No such slave
    } cdp_ack_e;

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_SETUP,
        BR_ACCESS,
        BR_ACK
    } br_state_e;

    // Port to bridge command, stable while req is high
    typedef struct packed {
        logic                        wr;
        logic [`MEMI_NR_SLAVES-1:0]  sel;
        logic [`MEMI_ADDR_WIDTH-1:0] addr;
        logic [31:0]                 wdata;
    } cdp_cmd_s;

    // Debug bus request, sel is one-hot
    typedef struct packed {
        logic [`MEMI_NR_SLAVES-1:0]  sel;
        logic                        wr_rd;
        logic [`MEMI_ADDR_WIDTH-1:0] addr;
        logic [31:0]                 wdata;
    } memi_req_s;

endpackage

// File: logic/jtag_debug_top.sv
`timescale 1ns/100ps

module jtag_debug_top (
    input  logic tck,
    input  logic trst,
    input  logic tms,
    input  logic tdi,
    input  logic memi_clk,
    input  logic memi_rst,
    output logic tdo
);
    import jtag_debug_pkg::*;

    // TAP strobes
    logic state_test_logic_reset;
    logic state_capture_dr;
    logic state_shift_dr;
    logic state_update_dr;
    logic state_capture_ir;
    logic state_shift_ir;
    logic state_update_ir;

    logic insn_cdpacc_select;
    logic cdpacc_tdo;

    // Clock crossing
    logic        xfer_req;
    cdp_cmd_s    xfer_cmd;
    logic        xfer_ack;
    logic [31:0] xfer_rdata;

    // Debug bus
    memi_req_s   memi;
    logic [31:0] memi_rdata;

    jtag_tap_fsm u_tap_fsm (
        .tck                    (tck),
        .trst                   (trst),
        .tms                    (tms),
        .state                  (),
        .state_test_logic_reset (state_test_logic_reset),
        .state_capture_dr       (state_capture_dr),
        .state_shift_dr         (state_shift_dr),
        .state_update_dr        (state_update_dr),
        .state_capture_ir       (state_capture_ir),
        .state_shift_ir         (state_shift_ir),
        .state_update_ir        (state_update_ir)
    );

    jtag_ir u_ir (
        .tck                    (tck),
        .state_test_logic_reset (state_test_logic_reset),
        .state_capture_ir       (state_capture_ir),
        .state_shift_ir         (state_shift_ir),
        .state_update_ir        (state_update_ir),
        .state_capture_dr       (state_capture_dr),
        .state_shift_dr         (state_shift_dr),
        .tdi                    (tdi),
        .cdpacc_tdo             (cdpacc_tdo),
        .insn_cdpacc_select     (insn_cdpacc_select),
        .tdo                    (tdo)
    );

    core_dbg_port u_cdp (
        .tck                    (tck),
        .state_test_logic_reset (state_test_logic_reset),
        .insn_cdpacc_select     (insn_cdpacc_select),
        .state_capture_dr       (state_capture_dr),
        .state_shift_dr         (state_shift_dr),
        .state_update_dr        (state_update_dr),
        .tdi                    (tdi),
        .cdpacc_tdo             (cdpacc_tdo),
        .xfer_req               (xfer_req),
        .xfer_cmd               (xfer_cmd),
        .xfer_ack               (xfer_ack),
        .xfer_rdata             (xfer_rdata)
    );

    cdp_memi_bridge u_bridge (
        .memi_clk   (memi_clk),
        .memi_rst   (memi_rst),
        .xfer_req   (xfer_req),
        .xfer_cmd   (xfer_cmd),
        .xfer_ack   (xfer_ack),
        .xfer_rdata (xfer_rdata),
        .memi       (memi),
        .memi_rdata (memi_rdata)
    );

    dbg_reg_bank u_bank (
        .memi_clk   (memi_clk),
        .memi_rst   (memi_rst),
        .memi       (memi),
        .memi_rdata (memi_rdata)
    );

endmodule

// File: logic/jtag_ir.sv
`timescale 1ns/100ps
`include "jtag_debug_params.svh"

module jtag_ir (
    input  logic tck,
    input  logic state_test_logic_reset,
    input  logic state_capture_ir,
    input  logic state_shift_ir,
    input  logic state_update_ir,
    input  logic state_capture_dr,
    input  logic state_shift_dr,
    input  logic tdi,
    input  logic cdpacc_tdo,
    output logic insn_cdpacc_select,
    output logic tdo
);
    import jtag_debug_pkg::*;

    logic [`JTAG_IR_LEN-1:0] ir_shift;   // IR scan chain
    jtag_insn_e              insn;       // Active instruction
    logic [31:0]             idcode_reg;
    logic                    bypass_reg;

    always_ff @(posedge tck) begin
        if (state_test_logic_reset) begin
            ir_shift <= '0;
            insn     <= INSN_IDCODE; // IDCODE selected out of reset
        end else if (state_capture_ir) begin
            ir_shift <= `JTAG_IR_LEN'(1); // Fixed 0001 capture pattern
        end else if (state_shift_ir) begin
            ir_shift <= {tdi, ir_shift[`JTAG_IR_LEN-1:1]}; // LSB first
        end else if (state_update_ir) begin
            insn <= jtag_insn_e'(ir_shift);
        end
    end

    // IDCODE and BYPASS data registers
    always_ff @(posedge tck) begin
        if (state_capture_dr) begin
            idcode_reg <= `JTAG_IDCODE;
            bypass_reg <= 1'b0;
        end else if (state_shift_dr) begin
            idcode_reg <= {tdi, idcode_reg[31:1]};
            bypass_reg <= tdi; // One-bit delay
        end
    end

    assign insn_cdpacc_select = (insn == INSN_CDPACC);

    always_comb begin
        if (state_shift_ir) begin
            tdo = ir_shift[0];
        end else begin
            case (insn)
                INSN_IDCODE: tdo = idcode_reg[0];
                INSN_CDPACC: tdo = cdpacc_tdo;
                default:     tdo = bypass_reg; // Unknown codes behave as BYPASS
            endcase
        end
    end

endmodule

// File: logic/jtag_tap_fsm.sv
`timescale 1ns/100ps

module jtag_tap_fsm (
    input  logic                     tck,
    input  logic                     trst,
    input  logic                     tms,
    output jtag_debug_pkg::tap_state_e state,
    output logic                     state_test_logic_reset,
    output logic                     state_capture_dr,
    output logic                     state_shift_dr,
    output logic                     state_update_dr,
    output logic                     state_capture_ir,
    output logic                     state_shift_ir,
    output logic                     state_update_ir
);
    import jtag_debug_pkg::*;

    tap_state_e next_state;

    always_ff @(posedge tck) begin
        if (trst) begin
            state <= TEST_LOGIC_RESET; // Async-free forced reset
        end else begin
            state <= next_state;
        end
    end

    // IEEE 1149.1 transitions
    always_comb begin
        case (state)
            TEST_LOGIC_RESET: next_state = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    next_state = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   next_state = tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:       next_state = tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         next_state = tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         next_state = tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         next_state = tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         next_state = tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        next_state = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   next_state = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       next_state = tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         next_state = tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         next_state = tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         next_state = tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         next_state = tms ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:        next_state = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            default:          next_state = TEST_LOGIC_RESET;
        endcase
    end

    // Strobes for the IR and DR logic
    assign state_test_logic_reset = (state == TEST_LOGIC_RESET); // Reset for tck domain
    assign state_capture_dr       = (state == CAPTURE_DR);
    assign state_shift_dr         = (state == SHIFT_DR);
    assign state_update_dr        = (state == UPDATE_DR);
    assign state_capture_ir       = (state == CAPTURE_IR);
    assign state_shift_ir         = (state == SHIFT_IR);
    assign state_update_ir        = (state == UPDATE_IR);

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module jtag_debug_tb -f jtag_debug_top.f -o jtag_debug_sim
./obj_dir/jtag_debug_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
    exit 0
else
    exit 1
fi

// File: verification/jtag_debug_stimulus.txt
# name kind sel addr data exp_ack exp_data
# sel decimal, other fields hex; ack 1=OK 2=WAIT 4=FAULT
idcode IDCODE 0 00 00000000 1 1BA00477
wr_s0_a03 WRITE 0 03 12345678 1 00000000
rd_s0_a03 READ 0 03 00000000 1 12345678
wr_s1_a03 WRITE 1 03 A5A5F00F 1 00000000
rd_s1_a03 READ 1 03 00000000 1 A5A5F00F
rd_s0_a03_again READ 0 03 00000000 1 12345678
rd_s0_a07_blank READ 0 07 00000000 1 00000000
rd_s1_a1f_blank READ 1 1F 00000000 1 00000000
wr_s1_a1f WRITE 1 1F DEADBEEF 1 00000000
rd_s1_a1f READ 1 1F 00000000 1 DEADBEEF
badsel_2 BADSEL 2 03 FFFFFFFF 4 00000000
rd_s0_after_bad READ 0 03 00000000 1 12345678
rd_s1_after_bad READ 1 03 00000000 1 A5A5F00F
badsel_7 BADSEL 7 1F 0BADF00D 4 00000000
rd_s1_a1f_after_bad READ 1 1F 00000000 1 DEADBEEF
busy_s0_a10 BUSY 0 10 CAFE0005 2 35010005
rd_s0_a10 READ 0 10 00000000 1 35010005

// File: verification/jtag_debug_tb.sv
`timescale 1ns/100ps
`include "jtag_debug_params.svh"

module jtag_debug_tb;
    import jtag_debug_pkg::*;

    localparam int POLL_LIMIT = 16; // Max CDPACC polls per access

    logic tck;
    logic trst;
    logic tms;
    logic tdi;
    logic memi_clk;
    logic memi_rst;
    logic tdo;

    int    tests_run;
    int    tests_failed;
    int    errors;
    logic  test_ok;
    string test_name;
    logic  dummy_bit;

    jtag_debug_top uut (
        .tck      (tck),
        .trst     (trst),
        .tms      (tms),
        .tdi      (tdi),
        .memi_clk (memi_clk),
        .memi_rst (memi_rst),
        .tdo      (tdo)
    );

    always #20 tck = ~tck;          // 40 ns JTAG clock
    always #5 memi_clk = ~memi_clk; // Bus clock at 4x tck

    // Drive on rising tck, sample tdo mid-cycle before the next shift edge
    task automatic jtag_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
        @(posedge tck);
        tms <= tms_v;
        tdi <= tdi_v;
        @(negedge tck);
        tdo_v = tdo;
    endtask

    task automatic idle_cycles(input int n);
        logic b;
        for (int i = 0; i < n; i++) begin
            jtag_step(1'b0, 1'b0, b); // Stay in Run-Test/Idle
        end
    endtask

    // Shift-DR or Shift-IR body, LSB first, leaves through Exit1
    task automatic shift_bits(input int len, input logic [63:0] din, output logic [63:0] dout);
        logic b;
        dout = '0;
        for (int i = 0; i < len; i++) begin
            jtag_step((i == len - 1), din[i], b);
            dout[i] = b;
        end
    endtask

    task automatic load_ir(input logic [3:0] code);
        logic [63:0] out;
        logic        b;
        jtag_step(1'b1, 1'b0, b); // Select-DR
        jtag_step(1'b1, 1'b0, b); // Select-IR
        jtag_step(1'b0, 1'b0, b); // Capture-IR
        jtag_step(1'b0, 1'b0, b); // Shift-IR
        shift_bits(`JTAG_IR_LEN, {60'b0, code}, out);
        jtag_step(1'b1, 1'b0, b); // Update-IR
        jtag_step(1'b0, 1'b0, b); // Back to idle
    endtask

    task automatic shift_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
        logic b;
        jtag_step(1'b1, 1'b0, b);
        jtag_step(1'b0, 1'b0, b);
        jtag_step(1'b0, 1'b0, b);
        shift_bits(len, din, dout);
        jtag_step(1'b1, 1'b0, b); // Update-DR
        jtag_step(1'b0, 1'b0, b);
    endtask

    // CDPACC frame is data[35:4], op[3:1], wr[0]
    task automatic cdp_cmd(input logic [2:0] op, input logic wr, input logic [31:0] data);
        logic [63:0] out;
        shift_dr(`CDP_DR_LEN, {28'b0, data, op, wr}, out);
    endtask

    // Poll with a TADDR rewrite of the same address, which has no side effect
    task automatic cdp_poll(input logic [4:0] addr, output logic [3:0] ack,
                            output logic [31:0] rdata);
        logic [63:0] out;
        int          n;
        logic        timed_out;
        n         = 0;
        timed_out = 1'b1;
        ack       = ACK_WAIT;
        rdata     = '0;
        while (timed_out && n < POLL_LIMIT) begin
            shift_dr(`CDP_DR_LEN, {28'b0, 27'b0, addr, 3'(OP_TADDR), 1'b0}, out);
            ack   = out[3:0];
            rdata = out[35:4];
            if (ack != ACK_WAIT) begin
                timed_out = 1'b0;
            end
            n++;
        end
        if (timed_out) begin
            $display("%s: ACK still WAIT after %0d polls, access never completed",
                     test_name, POLL_LIMIT);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s %s: expected %08h actual %08h", test_name, what, exp, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_ok   = 1'b1;
        tests_run++;
    endtask

    task automatic finish_test();
        if (test_ok) begin
            $display("test %s passed", test_name);
        end else begin
            $display("test %s failed", test_name);
            tests_failed++;
        end
    endtask

    task automatic run_idcode(input logic [31:0] exp_data);
        logic [63:0] out;
        load_ir(INSN_IDCODE);
        shift_dr(32, 64'b0, out);
        check_value("idcode", exp_data, out[31:0]);
    endtask

    task automatic run_write(input int sel, input logic [4:0] addr, input logic [31:0] data,
                             input logic [3:0] exp_ack);
        logic [3:0]  ack;
        logic [31:0] rd;
        load_ir(INSN_CDPACC);
        cdp_cmd(OP_SELECT, 1'b0, 32'(sel));
        cdp_cmd(OP_TADDR, 1'b0, {27'b0, addr});
        cdp_cmd(OP_DTR, 1'b1, data);
        cdp_poll(addr, ack, rd);
        check_value("write ack", {28'b0, exp_ack}, {28'b0, ack});
    endtask

    task automatic run_read(input int sel, input logic [4:0] addr, input logic [3:0] exp_ack,
                            input logic [31:0] exp_data);
        logic [3:0]  ack;
        logic [31:0] rd;
        load_ir(INSN_CDPACC);
        cdp_cmd(OP_SELECT, 1'b0, 32'(sel));
        cdp_cmd(OP_TADDR, 1'b0, {27'b0, addr});
        cdp_cmd(OP_DTR, 1'b0, 32'b0);
        cdp_poll(addr, ack, rd);
        check_value("read ack", {28'b0, exp_ack}, {28'b0, ack});
        check_value("read data", exp_data, rd);
    endtask

    // Out-of-range SELECT, then a valid SELECT must clear FAULT
    task automatic run_badsel(input int sel, input logic [4:0] addr, input logic [31:0] data,
                              input logic [3:0] exp_ack);
        logic [3:0]  ack;
        logic [31:0] rd;
        load_ir(INSN_CDPACC);
        cdp_cmd(OP_SELECT, 1'b0, 32'(sel));
        cdp_cmd(OP_TADDR, 1'b0, {27'b0, addr});
        cdp_cmd(OP_DTR, 1'b1, data);
        cdp_poll(addr, ack, rd);
        check_value("fault ack", {28'b0, exp_ack}, {28'b0, ack});
        cdp_cmd(OP_SELECT, 1'b0, 32'b0);
        cdp_poll(addr, ack, rd);
        check_value("ack after reselect", 32'(ACK_OK), {28'b0, ack});
    endtask

    // Back-to-back DTR; a read result with low bits 01 makes the short rescan decode as DTR
    task automatic run_busy(input int sel, input logic [4:0] addr, input logic [31:0] data,
                            input logic [3:0] exp_ack, input logic [31:0] exp_data);
        logic [3:0]  ack;
        logic [31:0] rd;
        logic [63:0] out;
        logic        b;
        load_ir(INSN_CDPACC);
        cdp_cmd(OP_SELECT, 1'b0, 32'(sel));
        cdp_cmd(OP_TADDR, 1'b0, {27'b0, addr});
        cdp_cmd(OP_DTR, 1'b1, data);
        cdp_poll(addr, ack, rd);
        cdp_cmd(OP_DTR, 1'b0, 32'b0);
        cdp_poll(addr, ack, rd);
        check_value("preload readback", data, rd);
        jtag_step(1'b1, 1'b0, b);
        jtag_step(1'b0, 1'b0, b);
        jtag_step(1'b0, 1'b0, b);
        shift_bits(`CDP_DR_LEN, {28'b0, exp_data, 3'(OP_DTR), 1'b1}, out);
        jtag_step(1'b1, 1'b0, b);  // Update-DR starts the write
        jtag_step(1'b1, 1'b0, b);  // Straight to Select-DR
        jtag_step(1'b0, 1'b0, b);  // Capture while handshake runs
        jtag_step(1'b0, 1'b0, b);
        shift_bits(2, 64'b0, out); // Only ack[1:0] comes out
        jtag_step(1'b1, 1'b0, b);  // Second Update-DR, dropped
        jtag_step(1'b0, 1'b0, b);
        check_value("busy ack", {30'b0, exp_ack[1:0]}, {30'b0, out[1:0]});
        cdp_poll(addr, ack, rd);
        check_value("ack after busy", 32'(ACK_OK), {28'b0, ack});
        cdp_cmd(OP_DTR, 1'b0, 32'b0);
        cdp_poll(addr, ack, rd);
        check_value("first access data", exp_data, rd);
    endtask

    initial begin
        int          fd;
        int          code;
        string       line;
        string       name;
        string       kind;
        int          sel;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_ack;
        logic [31:0] exp_data;
        logic [63:0] out;
        logic [63:0] pattern;

        tck          = 1'b0;
        memi_clk     = 1'b0;
        trst         = 1'b1;
        memi_rst     = 1'b1;
        tms          = 1'b1;
        tdi          = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        errors       = 0;
        void'($urandom(37));

        repeat (3) @(posedge tck);
        trst     <= 1'b0;
        memi_rst <= 1'b0;
        jtag_step(1'b0, 1'b0, dummy_bit); // Test-Logic-Reset to idle

        start_test("reset_idcode"); // IR must default to IDCODE
        shift_dr(32, 64'b0, out);
        check_value("idcode", `JTAG_IDCODE, out[31:0]);
        finish_test();

        start_test("bypass");
        load_ir(INSN_BYPASS);
        pattern = {55'b0, 9'h14B};
        shift_dr(9, pattern, out);
        check_value("bypass out", {23'b0, pattern[7:0], 1'b0}, {23'b0, out[8:0]});
        finish_test();

        fd = $fopen("verification/jtag_debug_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != 8'h23) begin // Skip # lines
                    code = $sscanf(line, "%s %s %d %h %h %h %h",
                                   name, kind, sel, addr, data, exp_ack, exp_data);
                    if (code == 7) begin
                        start_test(name);
                        if (kind == "IDCODE") begin
                            run_idcode(exp_data);
                        end else if (kind == "WRITE") begin
                            run_write(sel, addr[4:0], data, exp_ack[3:0]);
                        end else if (kind == "READ") begin
                            run_read(sel, addr[4:0], exp_ack[3:0], exp_data);
                        end else if (kind == "BADSEL") begin
                            run_badsel(sel, addr[4:0], data, exp_ack[3:0]);
                        end else if (kind == "BUSY") begin
                            run_busy(sel, addr[4:0], data, exp_ack[3:0], exp_data);
                        end else begin
                            $display("%s: unknown test kind %s", name, kind);
                            test_ok = 1'b0;
                        end
                        finish_test();
                        idle_cycles($urandom_range(3, 0)); // Random idle gap
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && errors == 0 && tests_run > 2) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Global limit on run time
    initial begin
        #5_000_000;
        $display("Simulation ran past its time limit, test %s never finished", test_name);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
